//--- hw/id_pkg.sv
`default_nettype none

package id_pkg;

    ////////////////////////////////////////////////////////////
    // widths
    ////////////////////////////////////////////////////////////
    localparam int XLEN         = 32;
    localparam int NUM_REGS     = 32;
    localparam int REG_IDX_BITS = 5;
    // tag 0 means the value lives in the register file
    localparam int ROB_TAG_BITS = 5;

    typedef logic [REG_IDX_BITS-1:0] reg_idx_t;
    typedef logic [ROB_TAG_BITS-1:0] rob_tag_t;
    typedef logic [XLEN-1:0]         word_t;

    ////////////////////////////////////////////////////////////
    // encodings
    ////////////////////////////////////////////////////////////
    typedef enum logic [6:0] {
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011,
        OPC_SYSTEM = 7'b1110011
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU, ALU_AND,
        ALU_OR, ALU_XOR, ALU_SLL, ALU_SRL, ALU_SRA
    } alu_func_e;

    typedef enum logic [1:0] {OPA_IS_RS1, OPA_IS_PC, OPA_IS_ZERO} opa_sel_e;

    typedef enum logic [2:0] {
        OPB_IS_RS2, OPB_IS_I_IMM, OPB_IS_S_IMM, OPB_IS_B_IMM, OPB_IS_U_IMM, OPB_IS_J_IMM
    } opb_sel_e;

    ////////////////////////////////////////////////////////////
    // packets
    ////////////////////////////////////////////////////////////
    typedef struct packed {logic valid; word_t pc; word_t inst;} fetch_pkt_t;

    typedef struct packed {
        opa_sel_e  opa_sel;
        opb_sel_e  opb_sel;
        alu_func_e alu_func;
        logic      has_dest;
        logic      rd_mem;
        logic      wr_mem;
        logic      cond_branch;
        logic      uncond_branch;
        logic      halt;
        logic      illegal;
    } ctrl_t;

    typedef struct packed {rob_tag_t tag; logic ready;} map_entry_t;

    typedef struct packed {logic valid; rob_tag_t tag; word_t value;} cdb_pkt_t;

    typedef struct packed {
        logic     valid;
        reg_idx_t dest_reg;
        rob_tag_t tag;
        word_t    value;
    } retire_pkt_t;

    // pending operand carries its tag in the low bits of value
    typedef struct packed {word_t value; logic valid;} operand_t;

    typedef struct packed {
        logic      valid;
        word_t     pc;
        operand_t  opa;
        operand_t  opb;
        reg_idx_t  dest_reg;
        rob_tag_t  rob_tag;
        alu_func_e alu_func;
        logic      rd_mem;
        logic      wr_mem;
        logic      is_branch;
        logic      halt;
        logic      illegal;
    } dispatch_pkt_t;

endpackage

`default_nettype wire

//--- hw/decoder.sv
`timescale 1ns/100ps
`default_nettype none

module decoder import id_pkg::*; (
    input  word_t inst,
    input  logic  valid,
    output ctrl_t ctrl
);

    localparam word_t WFI_INST = 32'h1050_0073;

    opcode_e    opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    assign opcode = opcode_e'(inst[6:0]);
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    always_comb begin
        // NOP defaults
        ctrl               = '0;
        ctrl.opa_sel       = OPA_IS_RS1;
        ctrl.opb_sel       = OPB_IS_RS2;
        ctrl.alu_func      = ALU_ADD;

        if (valid) begin
            case (opcode)
                OPC_LUI: begin
                    ctrl.has_dest = 1'b1;
                    ctrl.opa_sel  = OPA_IS_ZERO;
                    ctrl.opb_sel  = OPB_IS_U_IMM;
                end
                OPC_AUIPC: begin
                    ctrl.has_dest = 1'b1;
                    ctrl.opa_sel  = OPA_IS_PC;
                    ctrl.opb_sel  = OPB_IS_U_IMM;
                end
                OPC_JAL: begin
                    ctrl.has_dest      = 1'b1;
                    ctrl.opa_sel       = OPA_IS_PC;
                    ctrl.opb_sel       = OPB_IS_J_IMM;
                    ctrl.uncond_branch = 1'b1;
                end
                OPC_JALR: begin
                    ctrl.illegal       = (funct3 != 3'b000);
                    ctrl.has_dest      = !ctrl.illegal;
                    ctrl.opb_sel       = OPB_IS_I_IMM;
                    ctrl.uncond_branch = !ctrl.illegal;
                end
                OPC_BRANCH: begin
                    // funct3 010 and 011 are unused
                    ctrl.illegal     = (funct3[2:1] == 2'b01);
                    ctrl.opa_sel     = OPA_IS_PC;
                    ctrl.opb_sel     = OPB_IS_B_IMM;
                    ctrl.cond_branch = !ctrl.illegal;
                end
                OPC_LOAD: begin
                    ctrl.illegal  = (funct3 == 3'b011) || (funct3[2:1] == 2'b11);
                    ctrl.has_dest = !ctrl.illegal;
                    ctrl.opb_sel  = OPB_IS_I_IMM;
                    ctrl.rd_mem   = !ctrl.illegal;
                end
                OPC_STORE: begin
                    ctrl.illegal = (funct3[2] || funct3 == 3'b011);
                    ctrl.opb_sel = OPB_IS_S_IMM;
                    ctrl.wr_mem  = !ctrl.illegal;
                end
                OPC_OP_IMM: begin
                    ctrl.has_dest = 1'b1;
                    ctrl.opb_sel  = OPB_IS_I_IMM;
                    casez ({funct7, funct3})
                        10'b???????_000: ctrl.alu_func = ALU_ADD;
                        10'b???????_010: ctrl.alu_func = ALU_SLT;
                        10'b???????_011: ctrl.alu_func = ALU_SLTU;
                        10'b???????_100: ctrl.alu_func = ALU_XOR;
                        10'b???????_110: ctrl.alu_func = ALU_OR;
                        10'b???????_111: ctrl.alu_func = ALU_AND;
                        10'b0000000_001: ctrl.alu_func = ALU_SLL;
                        10'b0000000_101: ctrl.alu_func = ALU_SRL;
                        10'b0100000_101: ctrl.alu_func = ALU_SRA;
                        default: begin
                            ctrl.has_dest = 1'b0;
                            ctrl.illegal  = 1'b1;
                        end
                    endcase
                end
                OPC_OP: begin
                    ctrl.has_dest = 1'b1;
                    case ({funct7, funct3})
                        10'b0000000_000: ctrl.alu_func = ALU_ADD;
                        10'b0100000_000: ctrl.alu_func = ALU_SUB;
                        10'b0000000_001: ctrl.alu_func = ALU_SLL;
                        10'b0000000_010: ctrl.alu_func = ALU_SLT;
                        10'b0000000_011: ctrl.alu_func = ALU_SLTU;
                        10'b0000000_100: ctrl.alu_func = ALU_XOR;
                        10'b0000000_101: ctrl.alu_func = ALU_SRL;
                        10'b0100000_101: ctrl.alu_func = ALU_SRA;
                        10'b0000000_110: ctrl.alu_func = ALU_OR;
                        10'b0000000_111: ctrl.alu_func = ALU_AND;
                        default: begin
                            ctrl.has_dest = 1'b0;
                            ctrl.illegal  = 1'b1;
                        end
                    endcase
                end
                OPC_SYSTEM: begin
                    // only wfi is supported here
                    ctrl.halt    = (inst == WFI_INST);
                    ctrl.illegal = (inst != WFI_INST);
                end
                default: ctrl.illegal = 1'b1;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- hw/map_table.sv
`timescale 1ns/100ps
`default_nettype none

module map_table import id_pkg::*; (
    input  logic        clock,
    input  logic        rst,
    input  logic        flush,
    input  reg_idx_t    rs1_idx,
    input  reg_idx_t    rs2_idx,
    output map_entry_t  rs1_entry,
    output map_entry_t  rs2_entry,
    input  logic        alloc_en,
    input  reg_idx_t    alloc_idx,
    input  rob_tag_t    alloc_tag,
    input  cdb_pkt_t    cdb,
    input  retire_pkt_t retire
);

    map_entry_t entries [NUM_REGS];

    assign rs1_entry = entries[rs1_idx];
    assign rs2_entry = entries[rs2_idx];

    ////////////////////////////////////////////////////////////
    // per-entry update in rising priority order
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clock) begin
        if (rst || flush) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                entries[i] <= '0;
            end
        end else begin
            // x0 is never renamed
            for (int i = 1; i < NUM_REGS; i++) begin
                map_entry_t next;
                next = entries[i];

                // result broadcast
                if (cdb.valid && next.tag != '0 && next.tag == cdb.tag) begin
                    next.ready = 1'b1;
                end

                // retire clears only if still the youngest producer
                if (retire.valid && retire.dest_reg == reg_idx_t'(i) &&
                    entries[i].tag == retire.tag) begin
                    next = '0;
                end

                if (alloc_en && alloc_idx == reg_idx_t'(i)) begin
                    next.tag   = alloc_tag;
                    next.ready = 1'b0;
                end

                entries[i] <= next;
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/regfile.sv
`timescale 1ns/100ps
`default_nettype none

module regfile import id_pkg::*; (
    input  logic        clock,
    input  reg_idx_t    rd_idx_a,
    input  reg_idx_t    rd_idx_b,
    output word_t       rd_data_a,
    output word_t       rd_data_b,
    input  retire_pkt_t retire
);

    // x0 has no storage
    word_t regs [1:NUM_REGS-1];

    assign rd_data_a = (rd_idx_a == '0) ? '0 : regs[rd_idx_a];
    assign rd_data_b = (rd_idx_b == '0) ? '0 : regs[rd_idx_b];

    always_ff @(posedge clock) begin
        if (retire.valid && retire.dest_reg != '0) begin
            regs[retire.dest_reg] <= retire.value;
        end
    end

endmodule

`default_nettype wire

//--- hw/operand_select.sv
`timescale 1ns/100ps
`default_nettype none

module operand_select import id_pkg::*; (
    input  fetch_pkt_t fetch,
    input  ctrl_t      ctrl,
    input  map_entry_t rs1_entry,
    input  map_entry_t rs2_entry,
    input  word_t      rf_a,
    input  word_t      rf_b,
    input  word_t      rob_value_a,
    input  word_t      rob_value_b,
    output rob_tag_t   rob_read_tag_a,
    output rob_tag_t   rob_read_tag_b,
    output operand_t   opa,
    output operand_t   opb
);

    word_t    i_imm, s_imm, b_imm, u_imm, j_imm;
    word_t    inst;
    operand_t reg_a, reg_b;

    assign inst = fetch.inst;

    ////////////////////////////////////////////////////////////
    // immediates
    ////////////////////////////////////////////////////////////
    assign i_imm = {{20{inst[31]}}, inst[31:20]};
    assign s_imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign b_imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign u_imm = {inst[31:12], 12'b0};
    assign j_imm = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    // register file, ready ROB entry, or pending tag
    function automatic operand_t resolve(map_entry_t e, word_t rf_val, word_t rob_val);
        operand_t op;
        if (e.tag == '0) begin
            op.value = rf_val;
            op.valid = 1'b1;
        end else if (!e.ready) begin
            op.value = {{(XLEN-ROB_TAG_BITS){1'b0}}, e.tag};
            op.valid = 1'b0;
        end else begin
            op.value = rob_val;
            op.valid = 1'b1;
        end
        return op;
    endfunction

    assign reg_a = resolve(rs1_entry, rf_a, rob_value_a);
    assign reg_b = resolve(rs2_entry, rf_b, rob_value_b);

    // ask the ROB only for a ready producer
    assign rob_read_tag_a = (ctrl.opa_sel == OPA_IS_RS1 && rs1_entry.ready) ? rs1_entry.tag : '0;
    assign rob_read_tag_b = (ctrl.opb_sel == OPB_IS_RS2 && rs2_entry.ready) ? rs2_entry.tag : '0;

    always_comb begin
        case (ctrl.opa_sel)
            OPA_IS_PC:   opa = '{value: fetch.pc, valid: 1'b1};
            OPA_IS_ZERO: opa = '{value: '0, valid: 1'b1};
            default:     opa = reg_a;
        endcase
    end

    always_comb begin
        case (ctrl.opb_sel)
            OPB_IS_I_IMM: opb = '{value: i_imm, valid: 1'b1};
            OPB_IS_S_IMM: opb = '{value: s_imm, valid: 1'b1};
            OPB_IS_B_IMM: opb = '{value: b_imm, valid: 1'b1};
            OPB_IS_U_IMM: opb = '{value: u_imm, valid: 1'b1};
            OPB_IS_J_IMM: opb = '{value: j_imm, valid: 1'b1};
            default:      opb = reg_b;
        endcase
    end

endmodule

`default_nettype wire

//--- hw/stage_id.sv
`timescale 1ns/100ps
`default_nettype none

module stage_id import id_pkg::*; (
    input  logic          clock,
    input  logic          rst,
    input  fetch_pkt_t    fetch,
    input  rob_tag_t      rob_alloc_tag,
    input  logic          rob_free,
    input  logic          rs_free,
    input  logic          lsq_free,
    input  cdb_pkt_t      cdb,
    input  retire_pkt_t   retire,
    input  logic          flush,
    input  word_t         rob_value_a,
    input  word_t         rob_value_b,
    output dispatch_pkt_t dispatch,
    output rob_tag_t      rob_read_tag_a,
    output rob_tag_t      rob_read_tag_b
);

    ctrl_t      ctrl;
    map_entry_t rs1_entry, rs2_entry;
    word_t      rf_a, rf_b;
    operand_t   opa, opb;
    reg_idx_t   rs1_idx, rs2_idx, dest_reg;
    logic       dispatch_ok;
    logic       alloc_en;

    assign rs1_idx  = fetch.inst[19:15];
    assign rs2_idx  = fetch.inst[24:20];
    assign dest_reg = ctrl.has_dest ? fetch.inst[11:7] : '0;

    // all three back ends need room
    assign dispatch_ok = fetch.valid && rob_free && rs_free && lsq_free;
    assign alloc_en    = dispatch_ok && ctrl.has_dest && (dest_reg != '0);

    decoder decoder_inst (.inst(fetch.inst), .valid(fetch.valid), .ctrl(ctrl));

    map_table map_table_inst (
        .clock(clock), .rst(rst), .flush(flush),
        .rs1_idx(rs1_idx), .rs2_idx(rs2_idx),
        .rs1_entry(rs1_entry), .rs2_entry(rs2_entry),
        .alloc_en(alloc_en), .alloc_idx(dest_reg), .alloc_tag(rob_alloc_tag),
        .cdb(cdb), .retire(retire)
    );

    regfile regfile_inst (
        .clock(clock), .rd_idx_a(rs1_idx), .rd_idx_b(rs2_idx),
        .rd_data_a(rf_a), .rd_data_b(rf_b), .retire(retire)
    );

    operand_select operand_select_inst (
        .fetch(fetch), .ctrl(ctrl),
        .rs1_entry(rs1_entry), .rs2_entry(rs2_entry),
        .rf_a(rf_a), .rf_b(rf_b),
        .rob_value_a(rob_value_a), .rob_value_b(rob_value_b),
        .rob_read_tag_a(rob_read_tag_a), .rob_read_tag_b(rob_read_tag_b),
        .opa(opa), .opb(opb)
    );

    ////////////////////////////////////////////////////////////
    // dispatch packet
    ////////////////////////////////////////////////////////////
    assign dispatch.valid     = dispatch_ok;
    assign dispatch.pc        = fetch.pc;
    assign dispatch.opa       = opa;
    assign dispatch.opb       = opb;
    assign dispatch.dest_reg  = dest_reg;
    assign dispatch.rob_tag   = rob_alloc_tag;
    assign dispatch.alu_func  = ctrl.alu_func;
    assign dispatch.rd_mem    = ctrl.rd_mem;
    assign dispatch.wr_mem    = ctrl.wr_mem;
    assign dispatch.is_branch = ctrl.cond_branch || ctrl.uncond_branch;
    assign dispatch.halt      = ctrl.halt;
    assign dispatch.illegal   = ctrl.illegal;

endmodule

`default_nettype wire

//--- test/id_checker.sv
`timescale 1ns/100ps
`default_nettype none

module id_checker import id_pkg::*; (
    input  logic          clock,
    input  logic          check_en,
    input  int            row_idx,
    input  dispatch_pkt_t dispatch,
    input  rob_tag_t      rob_read_tag_a,
    input  rob_tag_t      rob_read_tag_b,
    input  logic          exp_valid,
    input  logic          exp_ops,
    input  word_t         exp_pc,
    input  rob_tag_t      exp_rob_tag,
    input  operand_t      exp_opa,
    input  operand_t      exp_opb,
    input  reg_idx_t      exp_dest,
    input  alu_func_e     exp_alu,
    input  logic [4:0]    exp_flags,
    input  rob_tag_t      exp_tag_a,
    input  rob_tag_t      exp_tag_b,
    output int            error_count,
    output int            row_count
);

    int         errs_seen = 0;
    int         rows_seen = 0;
    int         row_errs;
    logic [4:0] flags;

    assign error_count = errs_seen;
    assign row_count   = rows_seen;

    // same order as the flag column of the table
    assign flags = {dispatch.rd_mem, dispatch.wr_mem, dispatch.is_branch,
                    dispatch.halt, dispatch.illegal};

    task automatic compare_field(input string what, input logic [31:0] got,
                                 input logic [31:0] exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: row %0d %s is %h, expected %h",
                     $time, row_idx, what, got, exp);
            row_errs++;
        end
    endtask

    ////////////////////////////////////////////////////////////
    // compare one table row
    ////////////////////////////////////////////////////////////
    // DUT outputs settle after the falling edge
    always @(posedge clock) begin
        if (check_en) begin
            row_errs = 0;
            compare_field("dispatch.valid", 32'(dispatch.valid), 32'(exp_valid));
            if (exp_valid) begin
                compare_field("pc", dispatch.pc, exp_pc);
                compare_field("rob_tag", 32'(dispatch.rob_tag), 32'(exp_rob_tag));
                compare_field("dest_reg", 32'(dispatch.dest_reg), 32'(exp_dest));
                compare_field("alu_func", 32'(dispatch.alu_func), 32'(exp_alu));
                compare_field("flags", 32'(flags), 32'(exp_flags));
                if (exp_ops) begin
                    compare_field("opa.value", dispatch.opa.value, exp_opa.value);
                    compare_field("opa.valid", 32'(dispatch.opa.valid), 32'(exp_opa.valid));
                    compare_field("opb.value", dispatch.opb.value, exp_opb.value);
                    compare_field("opb.valid", 32'(dispatch.opb.valid), 32'(exp_opb.valid));
                    compare_field("rob_read_tag_a", 32'(rob_read_tag_a), 32'(exp_tag_a));
                    compare_field("rob_read_tag_b", 32'(rob_read_tag_b), 32'(exp_tag_b));
                end
            end
            errs_seen += row_errs;
            rows_seen++;
            if (row_errs == 0) begin
                $display("row %0d ok", row_idx);
            end else begin
                $display("row %0d has %0d wrong fields", row_idx, row_errs);
            end
        end
    end

endmodule

`default_nettype wire

//--- test/tb_stage_id.sv
`timescale 1ns/100ps
`default_nettype none

module tb_stage_id import id_pkg::*; ();

    typedef struct packed {
        fetch_pkt_t  fetch;
        logic [2:0]  free;
        rob_tag_t    alloc_tag;
        cdb_pkt_t    cdb;
        retire_pkt_t retire;
        logic        flush;
        logic        exp_valid;
        logic        exp_ops;
        operand_t    exp_opa;
        operand_t    exp_opb;
        reg_idx_t    exp_dest;
        alu_func_e   exp_alu;
        logic [4:0]  exp_flags;
        rob_tag_t    exp_tag_a;
        rob_tag_t    exp_tag_b;
    } row_t;

    logic          clock = 1'b0;
    logic          rst;
    fetch_pkt_t    fetch;
    rob_tag_t      rob_alloc_tag;
    logic          rob_free, rs_free, lsq_free;
    cdb_pkt_t      cdb;
    retire_pkt_t   retire;
    logic          flush;
    word_t         rob_value_a, rob_value_b;
    dispatch_pkt_t dispatch;
    rob_tag_t      rob_read_tag_a, rob_read_tag_b;

    row_t     rows [$];
    row_t     cur;
    cdb_pkt_t side_cdb;
    word_t    rob_data [32];
    logic     check_en;
    int       row_idx;
    int       cycles = 0;
    int       cycle_limit = 0;
    int       error_count, row_count;

    always #5 clock = ~clock;

    // ROB read ports answer combinationally from the array
    assign rob_value_a = rob_data[rob_read_tag_a];
    assign rob_value_b = rob_data[rob_read_tag_b];

    stage_id stage_id_inst (
        .clock(clock), .rst(rst), .fetch(fetch), .rob_alloc_tag(rob_alloc_tag),
        .rob_free(rob_free), .rs_free(rs_free), .lsq_free(lsq_free),
        .cdb(cdb), .retire(retire), .flush(flush),
        .rob_value_a(rob_value_a), .rob_value_b(rob_value_b),
        .dispatch(dispatch), .rob_read_tag_a(rob_read_tag_a), .rob_read_tag_b(rob_read_tag_b)
    );

    id_checker id_checker_inst (
        .clock(clock), .check_en(check_en), .row_idx(row_idx),
        .dispatch(dispatch), .rob_read_tag_a(rob_read_tag_a),
        .rob_read_tag_b(rob_read_tag_b),
        .exp_valid(cur.exp_valid), .exp_ops(cur.exp_ops),
        .exp_pc(cur.fetch.pc), .exp_rob_tag(cur.alloc_tag),
        .exp_opa(cur.exp_opa), .exp_opb(cur.exp_opb), .exp_dest(cur.exp_dest),
        .exp_alu(cur.exp_alu), .exp_flags(cur.exp_flags), .exp_tag_a(cur.exp_tag_a),
        .exp_tag_b(cur.exp_tag_b),
        .error_count(error_count), .row_count(row_count)
    );

    ////////////////////////////////////////////////////////////
    // RV32I encoders
    ////////////////////////////////////////////////////////////
    function automatic word_t r_type(input logic [6:0] f7, input reg_idx_t rs2,
                                     input reg_idx_t rs1, input logic [2:0] f3,
                                     input reg_idx_t rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic word_t i_type(input logic [11:0] imm, input reg_idx_t rs1,
                                     input logic [2:0] f3, input reg_idx_t rd,
                                     input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic word_t s_type(input logic [11:0] imm, input reg_idx_t rs2,
                                     input reg_idx_t rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
    endfunction

    function automatic word_t b_type(input logic [12:0] imm, input reg_idx_t rs2,
                                     input reg_idx_t rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic word_t u_type(input logic [19:0] imm, input reg_idx_t rd,
                                     input logic [6:0] opc);
        return {imm, rd, opc};
    endfunction

    function automatic word_t j_type(input logic [20:0] imm, input reg_idx_t rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    function automatic operand_t ready_op(input word_t value);
        return {value, 1'b1};
    endfunction

    function automatic operand_t pending_op(input rob_tag_t tag);
        return {27'b0, tag, 1'b0};
    endfunction

    function automatic retire_pkt_t commit(input reg_idx_t rd, input rob_tag_t tag,
                                           input word_t value);
        return {1'b1, rd, tag, value};
    endfunction

    function automatic word_t next_pc();
        return 32'h0000_1000 + 32'(4 * rows.size());
    endfunction

    // one instruction; it dispatches only when all three free flags are set
    task automatic dispatch_row(input word_t inst, input logic [2:0] free, input rob_tag_t tag,
                                input logic ops, input operand_t ea, input operand_t eb,
                                input reg_idx_t ed, input alu_func_e eu,
                                input logic [4:0] ef, input rob_tag_t eta,
                                input rob_tag_t etb = 5'd0);
        row_t r;
        r = '0;
        r.fetch     = {1'b1, next_pc(), inst};
        r.free      = free;
        r.alloc_tag = tag;
        r.cdb       = side_cdb;
        r.exp_valid = (free == 3'b111);
        r.exp_ops   = ops;
        r.exp_opa   = ea;
        r.exp_opb   = eb;
        r.exp_dest  = ed;
        r.exp_alu   = eu;
        r.exp_flags = ef;
        r.exp_tag_a = eta;
        r.exp_tag_b = etb;
        rows.push_back(r);
        side_cdb = '0;
    endtask

    task automatic idle_row(input retire_pkt_t rt, input logic fl);
        row_t r;
        r = '0;
        r.free   = 3'b111;
        r.retire = rt;
        r.flush  = fl;
        rows.push_back(r);
    endtask

    ////////////////////////////////////////////////////////////
    // stimulus table
    ////////////////////////////////////////////////////////////
    // free is {rob, rs, lsq}
    // flags are {rd_mem, wr_mem, is_branch, halt, illegal}
    task automatic build_table();
        word_t sub_x6;
        word_t addi_x1;
        word_t pc;
        sub_x6  = r_type(7'h20, 5'd1, 5'd5, 3'd0, 5'd6);
        addi_x1 = i_type(12'h001, 5'd0, 3'd0, 5'd1, 7'b0010011);
        idle_row(commit(5'd1, 5'd0, 32'h0000_0011), 1'b0);
        idle_row(commit(5'd2, 5'd0, 32'h0000_0022), 1'b0);
        dispatch_row(r_type(7'h00, 5'd2, 5'd1, 3'd0, 5'd3), 3'b111, 5'd1, 1'b1,
                     ready_op(32'h11), ready_op(32'h22), 5'd3, ALU_ADD, 5'b00000, 5'd0);
        // x5 gets tag 4, then the SUB waits on it
        dispatch_row(i_type(12'hffd, 5'd1, 3'd0, 5'd5, 7'b0010011), 3'b111, 5'd4, 1'b1,
                     ready_op(32'h11), ready_op(32'hffff_fffd), 5'd5, ALU_ADD, 5'b00000, 5'd0);
        side_cdb = {1'b1, 5'd4, 32'h0};
        dispatch_row(sub_x6, 3'b111, 5'd6, 1'b1,
                     pending_op(5'd4), ready_op(32'h11), 5'd6, ALU_SUB, 5'b00000, 5'd0);
        dispatch_row(sub_x6, 3'b111, 5'd7, 1'b1,
                     ready_op(rob_data[4]), ready_op(32'h11), 5'd6, ALU_SUB, 5'b00000, 5'd4);
        // operand B from a ready ROB entry
        dispatch_row(r_type(7'h00, 5'd5, 5'd1, 3'd0, 5'd0), 3'b111, 5'd8, 1'b1,
                     ready_op(32'h11), ready_op(rob_data[4]), 5'd0, ALU_ADD, 5'b00000, 5'd0,
                     5'd4);
        // back-pressure from the LSQ, then from the ROB
        dispatch_row(addi_x1, 3'b110, 5'd8, 1'b0, '0, '0, 5'd0, ALU_ADD, 5'b00000, 5'd0);
        dispatch_row(addi_x1, 3'b011, 5'd8, 1'b0, '0, '0, 5'd0, ALU_ADD, 5'b00000, 5'd0);
        dispatch_row(r_type(7'h00, 5'd3, 5'd1, 3'd0, 5'd8), 3'b111, 5'd9, 1'b1,
                     ready_op(32'h11), pending_op(5'd1), 5'd8, ALU_ADD, 5'b00000, 5'd0);
        dispatch_row(u_type(20'habcde, 5'd9, 7'b0110111), 3'b111, 5'd10, 1'b1,
                     ready_op(32'h0), ready_op(32'habcd_e000), 5'd9, ALU_ADD, 5'b00000, 5'd0);
        pc = next_pc();
        dispatch_row(u_type(20'h00001, 5'd10, 7'b0010111), 3'b111, 5'd11, 1'b1,
                     ready_op(pc), ready_op(32'h0000_1000), 5'd10, ALU_ADD, 5'b00000, 5'd0);
        pc = next_pc();
        dispatch_row(j_type(21'h1f_fff8, 5'd11), 3'b111, 5'd12, 1'b1,
                     ready_op(pc), ready_op(32'hffff_fff8), 5'd11, ALU_ADD, 5'b00100, 5'd0);
        pc = next_pc();
        dispatch_row(b_type(13'h0010, 5'd2, 5'd1, 3'd0), 3'b111, 5'd13, 1'b1,
                     ready_op(pc), ready_op(32'h10), 5'd0, ALU_ADD, 5'b00100, 5'd0);
        dispatch_row(i_type(12'hffc, 5'd2, 3'd2, 5'd12, 7'b0000011), 3'b111, 5'd14, 1'b1,
                     ready_op(32'h22), ready_op(32'hffff_fffc), 5'd12, ALU_ADD, 5'b10000, 5'd0);
        dispatch_row(s_type(12'hfec, 5'd2, 5'd1, 3'd2), 3'b111, 5'd15, 1'b1,
                     ready_op(32'h11), ready_op(32'hffff_ffec), 5'd0, ALU_ADD, 5'b01000, 5'd0);
        // matching retire of x5, stale retire of x3
        idle_row(commit(5'd5, 5'd4, 32'h0000_0055), 1'b0);
        idle_row(commit(5'd3, 5'd2, 32'h0000_0033), 1'b0);
        dispatch_row(r_type(7'h00, 5'd3, 5'd5, 3'd0, 5'd13), 3'b111, 5'd16, 1'b1,
                     ready_op(32'h55), pending_op(5'd1), 5'd13, ALU_ADD, 5'b00000, 5'd0);
        idle_row('0, 1'b1);
        dispatch_row(r_type(7'h00, 5'd2, 5'd3, 3'd0, 5'd14), 3'b111, 5'd17, 1'b1,
                     ready_op(32'h33), ready_op(32'h22), 5'd14, ALU_ADD, 5'b00000, 5'd0);
        dispatch_row(32'h0000_007f, 3'b111, 5'd18, 1'b0,
                     '0, '0, 5'd0, ALU_ADD, 5'b00001, 5'd0);
        dispatch_row(32'h1050_0073, 3'b111, 5'd19, 1'b0,
                     '0, '0, 5'd0, ALU_ADD, 5'b00010, 5'd0);
    endtask

    // ends the run if the table never finishes
    always @(posedge clock) begin
        cycles <= cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("timeout: run did not finish within %0d cycles", cycle_limit);
            $display("Test failed");
            $finish;
        end
    end

    initial begin
        rst           = 1'b1;
        fetch         = '0;
        rob_alloc_tag = '0;
        rob_free      = 1'b0;
        rs_free       = 1'b0;
        lsq_free      = 1'b0;
        cdb           = '0;
        retire        = '0;
        flush         = 1'b0;
        check_en      = 1'b0;
        row_idx       = 0;
        cur           = '0;
        side_cdb      = '0;
        for (int t = 0; t < 32; t++) begin
            rob_data[t] = 32'hc0de_0000 + 32'(t) * 32'h0000_0101;
        end
        build_table();
        cycle_limit = 4 * rows.size() + 20;

        repeat (3) @(posedge clock);
        @(negedge clock);
        rst = 1'b0;

        for (int i = 0; i < rows.size(); i++) begin
            @(negedge clock);
            cur           = rows[i];
            row_idx       = i;
            fetch         = cur.fetch;
            {rob_free, rs_free, lsq_free} = cur.free;
            rob_alloc_tag = cur.alloc_tag;
            cdb           = cur.cdb;
            retire        = cur.retire;
            flush         = cur.flush;
            check_en      = 1'b1;
        end

        @(negedge clock);
        check_en = 1'b0;
        fetch    = '0;
        cdb      = '0;
        retire   = '0;
        flush    = 1'b0;
        $display("rows checked %0d of %0d, errors %0d", row_count, rows.size(), error_count);
        if (error_count == 0 && row_count == rows.size()) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- stage_id.f
hw/id_pkg.sv
hw/decoder.sv
hw/map_table.sv
hw/regfile.sv
hw/operand_select.sv
hw/stage_id.sv
test/id_checker.sv
test/tb_stage_id.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the stage_id testbench with Verilator
set -u
cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing -f stage_id.f --top-module tb_stage_id --Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vtb_stage_id > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Test failed" "$LOG"; then
    exit 1
fi
exit 0
